/* design/cluster_addr_decoder.sv */
// Narrow port address decoder
// Steers each transaction to the TCDM or the peripherals, answers holes with slverr

`timescale 1ns/1ns
`default_nettype none

`include "cluster_macros.svh"

module cluster_addr_decoder (
  input  logic               clk,
  input  logic               rst_n,
  // Upstream narrow port
  input  logic               aw_valid,
  output logic               aw_ready,
  input  cluster_pkg::addr_t aw_addr,
  input  logic               w_valid,
  output logic               w_ready,
  input  cluster_pkg::data_t w_data,
  input  cluster_pkg::strb_t w_strb,
  output logic               b_valid,
  input  logic               b_ready,
  output cluster_pkg::resp_t b_resp,
  input  logic               ar_valid,
  output logic               ar_ready,
  input  cluster_pkg::addr_t ar_addr,
  output logic               r_valid,
  input  logic               r_ready,
  output cluster_pkg::data_t r_data,
  output cluster_pkg::resp_t r_resp,
  // TCDM target
  output logic               tcdm_aw_valid,
  input  logic               tcdm_aw_ready,
  output cluster_pkg::addr_t tcdm_aw_addr,
  output logic               tcdm_w_valid,
  input  logic               tcdm_w_ready,
  output cluster_pkg::data_t tcdm_w_data,
  output cluster_pkg::strb_t tcdm_w_strb,
  input  logic               tcdm_b_valid,
  output logic               tcdm_b_ready,
  input  cluster_pkg::resp_t tcdm_b_resp,
  output logic               tcdm_ar_valid,
  input  logic               tcdm_ar_ready,
  output cluster_pkg::addr_t tcdm_ar_addr,
  input  logic               tcdm_r_valid,
  output logic               tcdm_r_ready,
  input  cluster_pkg::data_t tcdm_r_data,
  input  cluster_pkg::resp_t tcdm_r_resp,
  // Peripheral target
  output logic               periph_aw_valid,
  input  logic               periph_aw_ready,
  output cluster_pkg::addr_t periph_aw_addr,
  output logic               periph_w_valid,
  input  logic               periph_w_ready,
  output cluster_pkg::data_t periph_w_data,
  output cluster_pkg::strb_t periph_w_strb,
  input  logic               periph_b_valid,
  output logic               periph_b_ready,
  input  cluster_pkg::resp_t periph_b_resp,
  output logic               periph_ar_valid,
  input  logic               periph_ar_ready,
  output cluster_pkg::addr_t periph_ar_addr,
  input  logic               periph_r_valid,
  output logic               periph_r_ready,
  input  cluster_pkg::data_t periph_r_data,
  input  cluster_pkg::resp_t periph_r_resp
);

  import cluster_pkg::*;

  localparam addr_t tcdm_base   = `CL_BASE_ADDR;
  localparam addr_t periph_base = `CL_BASE_ADDR + `CL_TCDM_BYTES;
  localparam addr_t periph_end  = periph_base + `CL_PERIPH_BYTES;

  typedef enum logic [1:0] {
    sel_tcdm,
    sel_periph,
    sel_none
  } sel_e;

  // Request forward, response collect, upstream response
  typedef enum logic [3:0] {
    d_idle,
    d_aw,
    d_w,
    d_wfwd,
    d_bwait,
    d_b,
    d_ar,
    d_rwait,
    d_r
  } dec_state_e;

  dec_state_e state;
  sel_e       sel;
  sel_e       aw_sel;
  sel_e       ar_sel;
  addr_t      dn_addr;
  data_t      dn_data;
  strb_t      dn_strb;
  resp_t      up_resp;
  data_t      up_data;
  logic       aw_hs;
  logic       w_hs;
  logic       ar_hs;
  logic       dn_aw_ready;
  logic       dn_w_ready;
  logic       dn_b_valid;
  resp_t      dn_b_resp;
  logic       dn_ar_ready;
  logic       dn_r_valid;
  data_t      dn_r_data;
  resp_t      dn_r_resp;

  function automatic sel_e decode(addr_t addr);
    if (addr >= tcdm_base && addr < periph_base) return sel_tcdm;
    if (addr >= periph_base && addr < periph_end) return sel_periph;
    return sel_none;
  endfunction

  function automatic addr_t window_offset(addr_t addr, sel_e target);
    return (target == sel_periph) ? addr - periph_base : addr - tcdm_base;
  endfunction

  assign aw_sel = decode(aw_addr);
  assign ar_sel = decode(ar_addr);

  ////////////////////
  // Upstream side

  // Address channels only open in idle, writes win a tie
  assign aw_ready = (state == d_idle);
  assign ar_ready = (state == d_idle) && !aw_valid;
  assign w_ready  = (state == d_w);
  assign b_valid  = (state == d_b);
  assign r_valid  = (state == d_r);
  assign b_resp   = up_resp;
  assign r_resp   = up_resp;
  assign r_data   = up_data;

  assign aw_hs = aw_valid && aw_ready;
  assign w_hs  = w_valid && w_ready;
  assign ar_hs = ar_valid && ar_ready;

  ////////////////////
  // Target side

  assign tcdm_aw_valid = (state == d_aw) && (sel == sel_tcdm);
  assign tcdm_w_valid  = (state == d_wfwd) && (sel == sel_tcdm);
  assign tcdm_b_ready  = (state == d_bwait) && (sel == sel_tcdm);
  assign tcdm_ar_valid = (state == d_ar) && (sel == sel_tcdm);
  assign tcdm_r_ready  = (state == d_rwait) && (sel == sel_tcdm);
  assign tcdm_aw_addr  = dn_addr;
  assign tcdm_ar_addr  = dn_addr;
  assign tcdm_w_data   = dn_data;
  assign tcdm_w_strb   = dn_strb;

  assign periph_aw_valid = (state == d_aw) && (sel == sel_periph);
  assign periph_w_valid  = (state == d_wfwd) && (sel == sel_periph);
  assign periph_b_ready  = (state == d_bwait) && (sel == sel_periph);
  assign periph_ar_valid = (state == d_ar) && (sel == sel_periph);
  assign periph_r_ready  = (state == d_rwait) && (sel == sel_periph);
  assign periph_aw_addr  = dn_addr;
  assign periph_ar_addr  = dn_addr;
  assign periph_w_data   = dn_data;
  assign periph_w_strb   = dn_strb;

  // Return path from the selected target
  assign dn_aw_ready = (sel == sel_periph) ? periph_aw_ready : tcdm_aw_ready;
  assign dn_w_ready  = (sel == sel_periph) ? periph_w_ready : tcdm_w_ready;
  assign dn_b_valid  = (sel == sel_periph) ? periph_b_valid : tcdm_b_valid;
  assign dn_b_resp   = (sel == sel_periph) ? periph_b_resp : tcdm_b_resp;
  assign dn_ar_ready = (sel == sel_periph) ? periph_ar_ready : tcdm_ar_ready;
  assign dn_r_valid  = (sel == sel_periph) ? periph_r_valid : tcdm_r_valid;
  assign dn_r_data   = (sel == sel_periph) ? periph_r_data : tcdm_r_data;
  assign dn_r_resp   = (sel == sel_periph) ? periph_r_resp : tcdm_r_resp;

  ////////////////////
  // Transaction FSM

  always_ff @(posedge clk) begin
    if (rst_n) begin
      state <= d_idle;
      sel   <= sel_none;
    end else begin
      case (state)
        d_idle: begin
          if (aw_hs) begin
            sel   <= aw_sel;
            state <= (aw_sel == sel_none) ? d_w : d_aw;
          end else if (ar_hs) begin
            sel   <= ar_sel;
            state <= (ar_sel == sel_none) ? d_r : d_ar;
          end
        end
        d_aw:    if (dn_aw_ready) state <= d_w;
        // Holes swallow the data beat here
        d_w:     if (w_valid) state <= (sel == sel_none) ? d_b : d_wfwd;
        d_wfwd:  if (dn_w_ready) state <= d_bwait;
        d_bwait: if (dn_b_valid) state <= d_b;
        d_b:     if (b_ready) state <= d_idle;
        d_ar:    if (dn_ar_ready) state <= d_rwait;
        d_rwait: if (dn_r_valid) state <= d_r;
        d_r:     if (r_ready) state <= d_idle;
        default: state <= d_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (aw_hs) begin
      dn_addr <= window_offset(aw_addr, aw_sel);
    end else if (ar_hs) begin
      dn_addr <= window_offset(ar_addr, ar_sel);
    end
    if (w_hs) begin
      dn_data <= w_data;
      dn_strb <= w_strb;
    end
    // Local error responses
    if (w_hs && sel == sel_none) begin
      up_resp <= resp_slverr;
    end
    if (ar_hs && ar_sel == sel_none) begin
      up_resp <= resp_slverr;
      up_data <= '0;
    end
    // Target responses
    if (state == d_bwait && dn_b_valid) begin
      up_resp <= dn_b_resp;
    end
    if (state == d_rwait && dn_r_valid) begin
      up_resp <= dn_r_resp;
      up_data <= dn_r_data;
    end
  end

  // Only one target answers at a time
  assert property (@(posedge clk) disable iff (rst_n)
    $onehot0({tcdm_b_valid, tcdm_r_valid, periph_b_valid, periph_r_valid}));

endmodule

`default_nettype wire

/* design/cluster_macros.svh */
// Cluster configuration
// Data path widths, core count, address map and peripheral register offsets

`ifndef CLUSTER_MACROS_SVH
`define CLUSTER_MACROS_SVH

// Narrow port widths
`define CL_ADDR_W 32
`define CL_DATA_W 32

// One msip line per core
`define CL_NR_CORES 4

// Address map
`define CL_BASE_ADDR    32'h1000_0000
`define CL_TCDM_BYTES   4096
`define CL_PERIPH_BYTES 256

// Peripheral register offsets within the peripheral window
`define CL_NR_SCRATCH         4
`define CL_REG_SCRATCH_OFS    32'h0000_0000
`define CL_REG_CLINT_SET_OFS  32'h0000_0010
`define CL_REG_CLINT_CLR_OFS  32'h0000_0014
`define CL_REG_CLINT_STAT_OFS 32'h0000_0018

`endif

/* design/cluster_periph_regs.sv */
// Cluster peripheral registers
// Scratch words plus the CL_CLINT set, clear and status registers driving msip

`timescale 1ns/1ns
`default_nettype none

`include "cluster_macros.svh"

module cluster_periph_regs (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    aw_valid,
  output logic                    aw_ready,
  input  cluster_pkg::addr_t      aw_addr,
  input  logic                    w_valid,
  output logic                    w_ready,
  input  cluster_pkg::data_t      w_data,
  input  cluster_pkg::strb_t      w_strb,
  output logic                    b_valid,
  input  logic                    b_ready,
  output cluster_pkg::resp_t      b_resp,
  input  logic                    ar_valid,
  output logic                    ar_ready,
  input  cluster_pkg::addr_t      ar_addr,
  output logic                    r_valid,
  input  logic                    r_ready,
  output cluster_pkg::data_t      r_data,
  output cluster_pkg::resp_t      r_resp,
  output cluster_pkg::core_mask_t msip
);

  import cluster_pkg::*;

  localparam int unsigned nr_bytes      = `CL_DATA_W / 8;
  localparam int unsigned scratch_idx_w = $clog2(`CL_NR_SCRATCH);
  localparam addr_t       scratch_end   = `CL_REG_SCRATCH_OFS + 4 * `CL_NR_SCRATCH;

  slave_state_e state;
  addr_t        wr_ofs;
  data_t        scratch [`CL_NR_SCRATCH];
  core_mask_t   pending;
  resp_t        b_resp_q;
  data_t        r_data_q;
  resp_t        r_resp_q;
  data_t        rd_data;
  resp_t        rd_resp;
  logic         aw_hs;
  logic         w_hs;
  logic         ar_hs;

  function automatic logic is_scratch(addr_t ofs);
    return ofs >= `CL_REG_SCRATCH_OFS && ofs < scratch_end && ofs[1:0] == 2'b00;
  endfunction

  function automatic logic [scratch_idx_w-1:0] scratch_idx(addr_t ofs);
    addr_t rel;
    rel = (ofs - `CL_REG_SCRATCH_OFS) >> 2;
    return rel[scratch_idx_w-1:0];
  endfunction

  assign aw_ready = (state == idle);
  assign ar_ready = (state == idle) && !aw_valid;
  assign w_ready  = (state == wait_wdata);
  assign b_valid  = (state == send_b);
  assign r_valid  = (state == send_r);
  assign b_resp   = b_resp_q;
  assign r_data   = r_data_q;
  assign r_resp   = r_resp_q;
  assign msip     = pending;

  assign aw_hs = aw_valid && aw_ready;
  assign w_hs  = w_valid && w_ready;
  assign ar_hs = ar_valid && ar_ready;

  // SET and CLR read back as zero
  always_comb begin
    rd_data = '0;
    rd_resp = resp_okay;
    if (is_scratch(ar_addr)) begin
      rd_data = scratch[scratch_idx(ar_addr)];
    end else if (ar_addr == `CL_REG_CLINT_STAT_OFS) begin
      rd_data = data_t'(pending);
    end else if (ar_addr != `CL_REG_CLINT_SET_OFS && ar_addr != `CL_REG_CLINT_CLR_OFS) begin
      rd_resp = resp_slverr;
    end
  end

  ////////////////////
  // FSM and registers

  always_ff @(posedge clk) begin
    if (rst_n) begin
      state   <= idle;
      pending <= '0;
      for (int i = 0; i < `CL_NR_SCRATCH; i++) begin
        scratch[i] <= '0;
      end
    end else begin
      case (state)
        idle: begin
          if (aw_hs) begin
            state <= wait_wdata;
          end else if (ar_hs) begin
            state <= send_r;
          end
        end
        wait_wdata: begin
          if (w_hs) begin
            state <= send_b;
            if (is_scratch(wr_ofs)) begin
              for (int b = 0; b < nr_bytes; b++) begin
                if (w_strb[b]) scratch[scratch_idx(wr_ofs)][8*b +: 8] <= w_data[8*b +: 8];
              end
            end else if (wr_ofs == `CL_REG_CLINT_SET_OFS) begin
              pending <= pending | w_data[`CL_NR_CORES-1:0];
            end else if (wr_ofs == `CL_REG_CLINT_CLR_OFS) begin
              pending <= pending & ~w_data[`CL_NR_CORES-1:0];
            end
          end
        end
        send_b:  if (b_ready) state <= idle;
        send_r:  if (r_ready) state <= idle;
        default: state <= idle;
      endcase
    end
  end

  // Response payloads
  always_ff @(posedge clk) begin
    if (aw_hs) begin
      wr_ofs <= aw_addr;
    end
    if (w_hs) begin
      b_resp_q <= (is_scratch(wr_ofs) || wr_ofs == `CL_REG_CLINT_SET_OFS ||
                   wr_ofs == `CL_REG_CLINT_CLR_OFS) ? resp_okay : resp_slverr;
    end
    if (ar_hs) begin
      r_data_q <= rd_data;
      r_resp_q <= rd_resp;
    end
  end

  // Interrupt lines move only as a result of a write beat
  assert property (@(posedge clk) disable iff (rst_n)
    !$stable(msip) |-> $past(w_valid && w_ready));

endmodule

`default_nettype wire

/* design/cluster_pkg.sv */
// Cluster package
// Shared vector types, response codes and the target slave states

`default_nettype none

`include "cluster_macros.svh"

package cluster_pkg;

  // Narrow port payloads
  typedef logic [`CL_ADDR_W-1:0]   addr_t;
  typedef logic [`CL_DATA_W-1:0]   data_t;
  typedef logic [`CL_DATA_W/8-1:0] strb_t;
  typedef logic [1:0]              resp_t;

  // One bit per core
  typedef logic [`CL_NR_CORES-1:0] core_mask_t;

  // AXI response codes
  localparam resp_t resp_okay   = 2'b00;
  localparam resp_t resp_slverr = 2'b10;

  // Single-outstanding target slave
  typedef enum logic [1:0] {
    idle,
    wait_wdata,
    send_b,
    send_r
  } slave_state_e;

endpackage

`default_nettype wire

/* design/cluster_tcdm.sv */
// Tightly coupled data memory
// Word array behind a single-outstanding AXI-lite slave with byte strobes

`timescale 1ns/1ns
`default_nettype none

`include "cluster_macros.svh"

module cluster_tcdm (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               aw_valid,
  output logic               aw_ready,
  input  cluster_pkg::addr_t aw_addr,
  input  logic               w_valid,
  output logic               w_ready,
  input  cluster_pkg::data_t w_data,
  input  cluster_pkg::strb_t w_strb,
  output logic               b_valid,
  input  logic               b_ready,
  output cluster_pkg::resp_t b_resp,
  input  logic               ar_valid,
  output logic               ar_ready,
  input  cluster_pkg::addr_t ar_addr,
  output logic               r_valid,
  input  logic               r_ready,
  output cluster_pkg::data_t r_data,
  output cluster_pkg::resp_t r_resp
);

  import cluster_pkg::*;

  localparam int unsigned nr_bytes = `CL_DATA_W / 8;
  localparam int unsigned nr_words = `CL_TCDM_BYTES / nr_bytes;
  localparam int unsigned idx_w    = $clog2(nr_words);

  slave_state_e     state;
  logic [idx_w-1:0] word_idx;
  data_t            mem [nr_words];
  data_t            rdata;
  logic             aw_hs;
  logic             w_hs;
  logic             ar_hs;

  assign aw_ready = (state == idle);
  assign ar_ready = (state == idle) && !aw_valid;
  assign w_ready  = (state == wait_wdata);
  assign b_valid  = (state == send_b);
  assign r_valid  = (state == send_r);
  assign b_resp   = resp_okay;
  assign r_resp   = resp_okay;
  assign r_data   = rdata;

  assign aw_hs = aw_valid && aw_ready;
  assign w_hs  = w_valid && w_ready;
  assign ar_hs = ar_valid && ar_ready;

  always_ff @(posedge clk) begin
    if (rst_n) begin
      state <= idle;
    end else begin
      case (state)
        idle: begin
          if (aw_hs) begin
            state <= wait_wdata;
          end else if (ar_hs) begin
            state <= send_r;
          end
        end
        wait_wdata: if (w_hs) state <= send_b;
        send_b:     if (b_ready) state <= idle;
        send_r:     if (r_ready) state <= idle;
        default:    state <= idle;
      endcase
    end
  end

  // Array and read data
  always_ff @(posedge clk) begin
    if (aw_hs) begin
      word_idx <= aw_addr[idx_w+1:2];
    end
    if (w_hs) begin
      for (int b = 0; b < nr_bytes; b++) begin
        if (w_strb[b]) mem[word_idx][8*b +: 8] <= w_data[8*b +: 8];
      end
    end
    if (ar_hs) begin
      rdata <= mem[ar_addr[idx_w+1:2]];
    end
  end

  // Data beat only after the address was taken
  assert property (@(posedge clk) disable iff (rst_n) (state == idle) |-> !w_valid);

endmodule

`default_nettype wire

/* design/mini_cluster_top.sv */
// Mini cluster top level
// Narrow port decoder feeding the TCDM and the peripheral register block

`timescale 1ns/1ns
`default_nettype none

module mini_cluster_top (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    aw_valid,
  output logic                    aw_ready,
  input  cluster_pkg::addr_t      aw_addr,
  input  logic                    w_valid,
  output logic                    w_ready,
  input  cluster_pkg::data_t      w_data,
  input  cluster_pkg::strb_t      w_strb,
  output logic                    b_valid,
  input  logic                    b_ready,
  output cluster_pkg::resp_t      b_resp,
  input  logic                    ar_valid,
  output logic                    ar_ready,
  input  cluster_pkg::addr_t      ar_addr,
  output logic                    r_valid,
  input  logic                    r_ready,
  output cluster_pkg::data_t      r_data,
  output cluster_pkg::resp_t      r_resp,
  output cluster_pkg::core_mask_t msip
);

  import cluster_pkg::*;

  // TCDM channels
  logic  tcdm_aw_valid, tcdm_aw_ready;
  addr_t tcdm_aw_addr;
  logic  tcdm_w_valid, tcdm_w_ready;
  data_t tcdm_w_data;
  strb_t tcdm_w_strb;
  logic  tcdm_b_valid, tcdm_b_ready;
  resp_t tcdm_b_resp;
  logic  tcdm_ar_valid, tcdm_ar_ready;
  addr_t tcdm_ar_addr;
  logic  tcdm_r_valid, tcdm_r_ready;
  data_t tcdm_r_data;
  resp_t tcdm_r_resp;

  // Peripheral channels
  logic  periph_aw_valid, periph_aw_ready;
  addr_t periph_aw_addr;
  logic  periph_w_valid, periph_w_ready;
  data_t periph_w_data;
  strb_t periph_w_strb;
  logic  periph_b_valid, periph_b_ready;
  resp_t periph_b_resp;
  logic  periph_ar_valid, periph_ar_ready;
  addr_t periph_ar_addr;
  logic  periph_r_valid, periph_r_ready;
  data_t periph_r_data;
  resp_t periph_r_resp;

  // Port names line up with the wires above
  cluster_addr_decoder u_decoder (.*);

  cluster_tcdm u_tcdm (
    .clk      (clk),
    .rst_n    (rst_n),
    .aw_valid (tcdm_aw_valid),
    .aw_ready (tcdm_aw_ready),
    .aw_addr  (tcdm_aw_addr),
    .w_valid  (tcdm_w_valid),
    .w_ready  (tcdm_w_ready),
    .w_data   (tcdm_w_data),
    .w_strb   (tcdm_w_strb),
    .b_valid  (tcdm_b_valid),
    .b_ready  (tcdm_b_ready),
    .b_resp   (tcdm_b_resp),
    .ar_valid (tcdm_ar_valid),
    .ar_ready (tcdm_ar_ready),
    .ar_addr  (tcdm_ar_addr),
    .r_valid  (tcdm_r_valid),
    .r_ready  (tcdm_r_ready),
    .r_data   (tcdm_r_data),
    .r_resp   (tcdm_r_resp)
  );

  cluster_periph_regs u_periph (
    .clk      (clk),
    .rst_n    (rst_n),
    .aw_valid (periph_aw_valid),
    .aw_ready (periph_aw_ready),
    .aw_addr  (periph_aw_addr),
    .w_valid  (periph_w_valid),
    .w_ready  (periph_w_ready),
    .w_data   (periph_w_data),
    .w_strb   (periph_w_strb),
    .b_valid  (periph_b_valid),
    .b_ready  (periph_b_ready),
    .b_resp   (periph_b_resp),
    .ar_valid (periph_ar_valid),
    .ar_ready (periph_ar_ready),
    .ar_addr  (periph_ar_addr),
    .r_valid  (periph_r_valid),
    .r_ready  (periph_r_ready),
    .r_data   (periph_r_data),
    .r_resp   (periph_r_resp),
    .msip     (msip)
  );

endmodule

`default_nettype wire

/* mini_cluster.f */
+incdir+design
+incdir+sim
design/cluster_pkg.sv
design/cluster_addr_decoder.sv
design/cluster_tcdm.sv
design/cluster_periph_regs.sv
design/mini_cluster_top.sv
sim/tb_mini_cluster.sv

/* sim/cluster_vip_tasks.svh */
// Narrow port bus tasks
// Single-beat AXI-lite write and read with handshake waits, plus the stimulus LCG

`ifndef CLUSTER_VIP_TASKS_SVH
`define CLUSTER_VIP_TASKS_SVH

// Inputs change 1 ns after the rising edge, outputs are sampled there too
task automatic next_cycle();
  @(posedge clk);
  #1;
endtask

// Numerical Recipes constants
function automatic logic [31:0] lcg_next();
  lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
  return lcg_state;
endfunction

// Address beat, then data beat, then the response held off for stall cycles
task automatic narrow_write(input addr_t addr, input data_t data, input strb_t strb,
                            input int unsigned stall, output resp_t resp);
  aw_valid = 1'b1;
  aw_addr  = addr;
  while (!aw_ready) begin
    next_cycle();
  end
  next_cycle();
  aw_valid = 1'b0;
  w_valid  = 1'b1;
  w_data   = data;
  w_strb   = strb;
  while (!w_ready) begin
    next_cycle();
  end
  next_cycle();
  w_valid = 1'b0;
  while (!b_valid) begin
    next_cycle();
  end
  repeat (stall) begin
    next_cycle();
  end
  b_ready = 1'b1;
  resp    = b_resp;
  next_cycle();
  b_ready = 1'b0;
endtask

task automatic narrow_read(input addr_t addr, input int unsigned stall,
                           output data_t data, output resp_t resp);
  ar_valid = 1'b1;
  ar_addr  = addr;
  while (!ar_ready) begin
    next_cycle();
  end
  next_cycle();
  ar_valid = 1'b0;
  while (!r_valid) begin
    next_cycle();
  end
  repeat (stall) begin
    next_cycle();
  end
  r_ready = 1'b1;
  data    = r_data;
  resp    = r_resp;
  next_cycle();
  r_ready = 1'b0;
endtask

`endif

/* sim/tb_mini_cluster.sv */
// Mini cluster testbench
// Drives the narrow port against TCDM, scratch and CL_CLINT models

`timescale 1ns/1ns
`default_nettype none

`include "cluster_macros.svh"

module tb_mini_cluster;

  import cluster_pkg::*;

  localparam addr_t tcdm_base      = `CL_BASE_ADDR;
  localparam addr_t periph_base    = `CL_BASE_ADDR + `CL_TCDM_BYTES;
  localparam addr_t periph_end     = periph_base + `CL_PERIPH_BYTES;
  localparam addr_t clint_set_addr = periph_base + `CL_REG_CLINT_SET_OFS;
  localparam addr_t clint_clr_addr = periph_base + `CL_REG_CLINT_CLR_OFS;
  localparam addr_t stat_addr      = periph_base + `CL_REG_CLINT_STAT_OFS;

  localparam int unsigned nr_words      = `CL_TCDM_BYTES / 4;
  localparam int unsigned nr_tcdm_words = 12;
  localparam int unsigned nr_bp_rounds  = 6;
  localparam logic [31:0] lcg_seed      = 32'd74079;

  // Reset, TCDM, scratch, CLINT, error and back-pressure groups
  localparam int unsigned nr_txn = 4 + 4 * nr_tcdm_words + 18 + 12 + 12 + 3 * nr_bp_rounds;
  localparam int unsigned timeout_cycles = nr_txn * 20 + 200;

  logic       clk;
  logic       rst_n;
  logic       aw_valid;
  logic       aw_ready;
  addr_t      aw_addr;
  logic       w_valid;
  logic       w_ready;
  data_t      w_data;
  strb_t      w_strb;
  logic       b_valid;
  logic       b_ready;
  resp_t      b_resp;
  logic       ar_valid;
  logic       ar_ready;
  addr_t      ar_addr;
  logic       r_valid;
  logic       r_ready;
  data_t      r_data;
  resp_t      r_resp;
  core_mask_t msip;

  // Reference models
  data_t       tcdm_model [nr_words];
  data_t       scratch_model [`CL_NR_SCRATCH];
  core_mask_t  msip_model;
  int unsigned word_list [$];
  logic [31:0] lcg_state;

  mini_cluster_top u_mini_cluster_top (.*);

  `include "cluster_vip_tasks.svh"

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TESTBENCH FAILED");
    $fatal(1);
  endtask

  task automatic check_value(input string test_name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected)
    else abort_run($sformatf("error %s expected 0x%08h actual 0x%08h",
                             test_name, expected, actual));
  endtask

  // Old bytes survive where the strobe is low
  function automatic data_t merge_bytes(data_t old_word, data_t new_word, strb_t strb);
    data_t merged;
    merged = old_word;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        merged[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return merged;
  endfunction

  task automatic write_expect(input string test_name, input addr_t addr, input data_t data,
                              input resp_t exp_resp, input int unsigned stall);
    resp_t resp;
    narrow_write(addr, data, 4'hF, stall, resp);
    check_value({test_name, "_resp"}, exp_resp, resp);
  endtask

  task automatic read_expect(input string test_name, input addr_t addr, input data_t exp_data,
                             input resp_t exp_resp, input int unsigned stall);
    data_t data;
    resp_t resp;
    narrow_read(addr, stall, data, resp);
    check_value({test_name, "_data"}, exp_data, data);
    check_value({test_name, "_resp"}, exp_resp, resp);
  endtask

  task automatic tcdm_write(input int unsigned idx, input data_t data, input strb_t strb,
                            input int unsigned stall);
    resp_t resp;
    narrow_write(tcdm_base + (idx << 2), data, strb, stall, resp);
    check_value("tcdm_write_resp", resp_okay, resp);
    tcdm_model[idx] = merge_bytes(tcdm_model[idx], data, strb);
  endtask

  task automatic tcdm_check(input int unsigned idx, input int unsigned stall);
    read_expect("tcdm_read", tcdm_base + (idx << 2), tcdm_model[idx], resp_okay, stall);
  endtask

  task automatic scratch_write(input int unsigned i, input data_t data);
    write_expect("scratch_write", periph_base + `CL_REG_SCRATCH_OFS + 4 * i, data,
                 resp_okay, 0);
    scratch_model[i] = data;
  endtask

  task automatic scratch_check(input string test_name, input int unsigned i,
                               input int unsigned stall);
    read_expect(test_name, periph_base + `CL_REG_SCRATCH_OFS + 4 * i, scratch_model[i],
                resp_okay, stall);
  endtask

  // SET ORs the mask in, CLR takes it out
  task automatic clint_write(input addr_t addr, input data_t data);
    write_expect("clint_write", addr, data, resp_okay, 0);
    if (addr == clint_set_addr) begin
      msip_model = msip_model | data[`CL_NR_CORES-1:0];
    end else begin
      msip_model = msip_model & ~data[`CL_NR_CORES-1:0];
    end
    check_value("clint_msip", msip_model, msip);
  endtask

  task automatic stat_check(input string test_name);
    read_expect(test_name, stat_addr, data_t'(msip_model), resp_okay, 0);
    check_value({test_name, "_msip"}, msip_model, msip);
  endtask

  ////////////////////
  // Protocol checks

  assert property (@(posedge clk) disable iff (rst_n)
    (b_valid && !b_ready) |=> (b_valid && $stable(b_resp)))
  else abort_run("b_valid dropped or b_resp changed while b_ready was low");

  assert property (@(posedge clk) disable iff (rst_n)
    (r_valid && !r_ready) |=> (r_valid && $stable(r_data) && $stable(r_resp)))
  else abort_run("r_valid dropped or r payload changed while r_ready was low");

  // Single outstanding transaction
  assert property (@(posedge clk) disable iff (rst_n)
    (b_valid || r_valid) |-> (!aw_ready && !ar_ready))
  else abort_run("an address channel was ready while a response was pending");

  ////////////////////
  // Clock, watchdog, sequence

  initial begin
    clk = 1'b0;
    forever begin
      #5 clk = ~clk;
    end
  end

  initial begin
    repeat (timeout_cycles) @(posedge clk);
    abort_run($sformatf("timeout after %0d cycles with the tests still running",
                        timeout_cycles));
  end

  initial begin
    int unsigned idx;
    int unsigned stall;
    data_t       data;
    rst_n      = 1'b1;
    aw_valid   = 1'b0;
    aw_addr    = '0;
    w_valid    = 1'b0;
    w_data     = '0;
    w_strb     = '0;
    b_ready    = 1'b0;
    ar_valid   = 1'b0;
    ar_addr    = '0;
    r_ready    = 1'b0;
    lcg_state  = lcg_seed;
    msip_model = '0;
    for (int i = 0; i < `CL_NR_SCRATCH; i++) begin
      scratch_model[i] = '0;
    end
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b0;
    next_cycle();

    // Reset state
    check_value("reset_msip", 0, msip);
    check_value("reset_b_valid", 0, b_valid);
    check_value("reset_r_valid", 0, r_valid);
    check_value("reset_w_ready", 0, w_ready);
    check_value("reset_aw_ready", 1, aw_ready);
    check_value("reset_ar_ready", 1, ar_ready);
    for (int i = 0; i < `CL_NR_SCRATCH; i++) begin
      scratch_check("reset_scratch", i, 0);
    end

    // TCDM full words, then partial strobes over the same words
    for (int i = 0; i < nr_tcdm_words; i++) begin
      idx = (lcg_next() >> 8) % nr_words;
      word_list.push_back(idx);
      tcdm_write(idx, lcg_next(), 4'hF, 0);
    end
    foreach (word_list[i]) begin
      tcdm_check(word_list[i], 0);
    end
    foreach (word_list[i]) begin
      data = lcg_next();
      tcdm_write(word_list[i], data, strb_t'(lcg_next() >> 12), 0);
    end
    foreach (word_list[i]) begin
      tcdm_check(word_list[i], 0);
    end

    // Scratch registers mixed with TCDM traffic
    for (int i = 0; i < `CL_NR_SCRATCH; i++) begin
      scratch_write(i, lcg_next());
    end
    tcdm_write(word_list[0], lcg_next(), 4'hF, 0);
    for (int i = 0; i < `CL_NR_SCRATCH; i++) begin
      scratch_check("scratch_read", i, 0);
    end
    tcdm_check(word_list[0], 0);
    for (int i = `CL_NR_SCRATCH - 1; i >= 0; i--) begin
      scratch_write(i, lcg_next());
    end
    for (int i = 0; i < `CL_NR_SCRATCH; i++) begin
      scratch_check("scratch_reread", i, 0);
    end

    // CL_CLINT set, clear and status
    clint_write(clint_set_addr, 32'h0000_0005);
    stat_check("clint_stat_set");
    clint_write(clint_set_addr, 32'hFFFF_FFFA);
    stat_check("clint_stat_accum");
    clint_write(clint_clr_addr, 32'h0000_0006);
    stat_check("clint_stat_clr");
    read_expect("clint_read_set", clint_set_addr, 0, resp_okay, 0);
    read_expect("clint_read_clr", clint_clr_addr, 0, resp_okay, 0);
    clint_write(clint_clr_addr, 32'h0000_000F);
    stat_check("clint_stat_empty");
    clint_write(clint_set_addr, 32'h0000_0009);
    stat_check("clint_stat_final");

    // Decode errors leave every target untouched
    write_expect("err_write_above", periph_end, lcg_next(), resp_slverr, 0);
    read_expect("err_read_above", periph_end + 32'h40, 0, resp_slverr, 0);
    read_expect("err_read_below", tcdm_base - 32'h10, 0, resp_slverr, 0);
    write_expect("err_write_hole", periph_base + 32'h1C, 32'hFFFF_FFFF, resp_slverr, 0);
    read_expect("err_read_hole", periph_base + 32'h40, 0, resp_slverr, 0);
    write_expect("err_write_stat", stat_addr, 32'h0000_000F, resp_slverr, 0);
    check_value("err_msip", msip_model, msip);
    tcdm_check(word_list[0], 0);
    for (int i = 0; i < `CL_NR_SCRATCH; i++) begin
      scratch_check("err_scratch", i, 0);
    end
    stat_check("err_stat");

    // Responses held off for a random number of cycles
    for (int r = 0; r < nr_bp_rounds; r++) begin
      idx   = word_list[r % word_list.size()];
      stall = 1 + (lcg_next() >> 20) % 8;
      tcdm_write(idx, lcg_next(), 4'hF, stall);
      stall = 1 + (lcg_next() >> 20) % 8;
      tcdm_check(idx, stall);
      stall = 1 + (lcg_next() >> 20) % 8;
      scratch_check("bp_scratch", r % `CL_NR_SCRATCH, stall);
    end

    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

`default_nettype wire
